// File: src/raster_pkg.sv
`default_nettype none

package raster_pkg;

    ////////////////////////////////////////
    // Screen
    ////////////////////////////////////////

    localparam int screen_w = 640;
    localparam int screen_h = 480;

    ////////////////////////////////////////
    // Coordinates and edge arithmetic
    ////////////////////////////////////////

    typedef logic [9:0] x_t;
    typedef logic [8:0] y_t;

    // Difference of two vertex coordinates
    typedef logic signed [10:0] coord_t;

    // Room for a product of two coord_t plus one more
    typedef logic signed [23:0] edge_t;

    ////////////////////////////////////////
    // Colour and FIFO word
    ////////////////////////////////////////

    typedef logic [15:0] rgb_t;

    // {line, column, colour}
    typedef logic [34:0] pixel_t;

    // Line 511 is off screen, so this is never a pixel
    localparam pixel_t flush_word = '1;

    typedef enum logic [1:0] {
        idle,
        setup,
        row,
        span
    } scan_state_t;

endpackage

`default_nettype wire

// File: src/tri_bbox.sv
`timescale 1ns/1ps
`default_nettype none

module tri_bbox (
    input  wire raster_pkg::x_t x1,
    input  wire raster_pkg::x_t x2,
    input  wire raster_pkg::x_t x3,
    input  wire raster_pkg::y_t y1,
    input  wire raster_pkg::y_t y2,
    input  wire raster_pkg::y_t y3,
    output raster_pkg::x_t      min_x,
    output raster_pkg::x_t      max_x,
    output raster_pkg::y_t      min_y,
    output raster_pkg::y_t      max_y,
    output logic                empty
);
    import raster_pkg::*;

    localparam x_t last_x = x_t'(screen_w - 1);
    localparam y_t last_y = y_t'(screen_h - 1);

    x_t lo_x;
    x_t hi_x;
    y_t lo_y;
    y_t hi_y;

    // Three-way min and max per axis
    always_comb
    begin
        lo_x = x1;
        hi_x = x1;
        lo_y = y1;
        hi_y = y1;
        if (x2 < lo_x) lo_x = x2;
        if (x3 < lo_x) lo_x = x3;
        if (x2 > hi_x) hi_x = x2;
        if (x3 > hi_x) hi_x = x3;
        if (y2 < lo_y) lo_y = y2;
        if (y3 < lo_y) lo_y = y3;
        if (y2 > hi_y) hi_y = y2;
        if (y3 > hi_y) hi_y = y3;
    end

    assign min_x = lo_x;
    assign min_y = lo_y;

    // Clip to the last visible column and line
    assign max_x = (hi_x > last_x) ? last_x : hi_x;
    assign max_y = (hi_y > last_y) ? last_y : hi_y;

    // No area left once the minimum is off screen
    assign empty = (lo_x > last_x) || (lo_y > last_y);

endmodule

`default_nettype wire

// File: src/edge_setup.sv
`timescale 1ns/1ps
`default_nettype none

module edge_setup (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   load,
    input  wire raster_pkg::x_t   v1_x,
    input  wire raster_pkg::y_t   v1_y,
    input  wire raster_pkg::x_t   v2_x,
    input  wire raster_pkg::y_t   v2_y,
    input  wire raster_pkg::x_t   v3_x,
    input  wire raster_pkg::y_t   v3_y,
    input  wire raster_pkg::rgb_t tri_color,
    output raster_pkg::x_t        min_x,
    output raster_pkg::x_t        max_x,
    output raster_pkg::y_t        min_y,
    output raster_pkg::y_t        max_y,
    output logic                  empty,
    output raster_pkg::edge_t     e1_init,
    output raster_pkg::edge_t     e2_init,
    output raster_pkg::edge_t     e3_init,
    output raster_pkg::edge_t     e1_dx,
    output raster_pkg::edge_t     e2_dx,
    output raster_pkg::edge_t     e3_dx,
    output raster_pkg::edge_t     e1_dy,
    output raster_pkg::edge_t     e2_dy,
    output raster_pkg::edge_t     e3_dy,
    output raster_pkg::rgb_t      color
);
    import raster_pkg::*;

    x_t x1;
    x_t x2;
    x_t x3;
    y_t y1;
    y_t y2;
    y_t y3;

    function automatic coord_t sub_x(x_t a, x_t b);
        return coord_t'({1'b0, a}) - coord_t'({1'b0, b});
    endfunction

    function automatic coord_t sub_y(y_t a, y_t b);
        return coord_t'({2'b00, a}) - coord_t'({2'b00, b});
    endfunction

    // ex * (y - yi) - ey * (x - xi)
    function automatic edge_t corner(coord_t ex, coord_t ey, coord_t ox, coord_t oy);
        return edge_t'(ex) * edge_t'(oy) - edge_t'(ey) * edge_t'(ox);
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            x1    <= '0;
            x2    <= '0;
            x3    <= '0;
            y1    <= '0;
            y2    <= '0;
            y3    <= '0;
            color <= '0;
        end
        else if (load)
        begin
            x1    <= v1_x;
            x2    <= v2_x;
            x3    <= v3_x;
            y1    <= v1_y;
            y2    <= v2_y;
            y3    <= v3_y;
            color <= tri_color;
        end
    end

    tri_bbox u_bbox (
        .x1    (x1),
        .x2    (x2),
        .x3    (x3),
        .y1    (y1),
        .y2    (y2),
        .y3    (y3),
        .min_x (min_x),
        .max_x (max_x),
        .min_y (min_y),
        .max_y (max_y),
        .empty (empty)
    );

    ////////////////////////////////////////
    // Edges 1->2, 2->3, 3->1
    ////////////////////////////////////////

    // Column step subtracts the y span, line step adds the x span
    assign e1_dx = edge_t'(sub_y(y2, y1));
    assign e2_dx = edge_t'(sub_y(y3, y2));
    assign e3_dx = edge_t'(sub_y(y1, y3));
    assign e1_dy = edge_t'(sub_x(x2, x1));
    assign e2_dy = edge_t'(sub_x(x3, x2));
    assign e3_dy = edge_t'(sub_x(x1, x3));

    assign e1_init = corner(sub_x(x2, x1), sub_y(y2, y1), sub_x(min_x, x1), sub_y(min_y, y1));
    assign e2_init = corner(sub_x(x3, x2), sub_y(y3, y2), sub_x(min_x, x2), sub_y(min_y, y2));
    assign e3_init = corner(sub_x(x1, x3), sub_y(y1, y3), sub_x(min_x, x3), sub_y(min_y, y3));

endmodule

`default_nettype wire

// File: src/raster_scan.sv
`timescale 1ns/1ps
`default_nettype none

module raster_scan (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    tri_valid,
    input  wire                    flush,
    input  wire                    full,
    input  wire raster_pkg::x_t    min_x,
    input  wire raster_pkg::x_t    max_x,
    input  wire raster_pkg::y_t    min_y,
    input  wire raster_pkg::y_t    max_y,
    input  wire                    empty,
    input  wire raster_pkg::edge_t e1_init,
    input  wire raster_pkg::edge_t e2_init,
    input  wire raster_pkg::edge_t e3_init,
    input  wire raster_pkg::edge_t e1_dx,
    input  wire raster_pkg::edge_t e2_dx,
    input  wire raster_pkg::edge_t e3_dx,
    input  wire raster_pkg::edge_t e1_dy,
    input  wire raster_pkg::edge_t e2_dy,
    input  wire raster_pkg::edge_t e3_dy,
    input  wire raster_pkg::rgb_t  color,
    output logic                   load,
    output logic                   raster_ready,
    output logic                   wr_en,
    output raster_pkg::pixel_t     wr_data
);
    import raster_pkg::*;

    scan_state_t state;

    x_t    cnt_x;
    y_t    cnt_y;
    edge_t init_v [3];
    edge_t dx_v [3];
    edge_t dy_v [3];
    edge_t row_e [3];
    edge_t run_e [3];
    logic  covered;
    logic  last_col;
    logic  row_done;

    assign init_v = '{e1_init, e2_init, e3_init};
    assign dx_v   = '{e1_dx, e2_dx, e3_dx};
    assign dy_v   = '{e1_dy, e2_dy, e3_dy};

    assign load     = raster_ready && tri_valid;
    assign covered  = (run_e[0] >= 0) && (run_e[1] >= 0) && (run_e[2] >= 0);
    assign last_col = (cnt_x == max_x);
    assign row_done = empty || (cnt_y > max_y);

    ////////////////////////////////////////
    // Control and FIFO write port
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= idle;
            raster_ready <= 1'b1;
            wr_en        <= 1'b0;
            wr_data      <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (wr_en)
                    begin
                        // Flush word held until the FIFO takes it
                        if (!full)
                        begin
                            wr_en        <= 1'b0;
                            raster_ready <= 1'b1;
                        end
                    end
                    else if (load)
                    begin
                        raster_ready <= 1'b0;
                        state        <= setup;
                    end
                    else if (raster_ready && flush)
                    begin
                        wr_en        <= 1'b1;
                        wr_data      <= flush_word;
                        raster_ready <= 1'b0;
                    end
                end
                setup:
                begin
                    if (!full)
                        state <= row;
                end
                row:
                begin
                    if (!full)
                    begin
                        wr_en <= 1'b0;
                        if (row_done)
                        begin
                            raster_ready <= 1'b1;
                            state        <= idle;
                        end
                        else
                            state <= span;
                    end
                end
                span:
                begin
                    // Any stall freezes the current word and the column
                    if (!full)
                    begin
                        wr_en <= covered;
                        if (covered)
                            wr_data <= pixel_t'({cnt_y, cnt_x, color});
                        if (last_col)
                            state <= row;
                    end
                end
                default:
                    state <= idle;
            endcase
        end
    end

    ////////////////////////////////////////
    // Counters and edge walkers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!full)
        begin
            case (state)
                setup:
                begin
                    row_e <= init_v;
                    cnt_y <= min_y;
                end
                row:
                begin
                    run_e <= row_e;
                    cnt_x <= min_x;
                    for (int k = 0; k < 3; k++)
                        row_e[k] <= row_e[k] + dy_v[k];
                end
                span:
                begin
                    for (int k = 0; k < 3; k++)
                        run_e[k] <= run_e[k] - dx_v[k];
                    if (last_col)
                        cnt_y <= cnt_y + 1'b1;
                    else
                        cnt_x <= cnt_x + 1'b1;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/rasterizer_top.sv
`timescale 1ns/1ps
`default_nettype none

module rasterizer_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   tri_valid,
    input  wire raster_pkg::x_t   v1_x,
    input  wire raster_pkg::y_t   v1_y,
    input  wire raster_pkg::x_t   v2_x,
    input  wire raster_pkg::y_t   v2_y,
    input  wire raster_pkg::x_t   v3_x,
    input  wire raster_pkg::y_t   v3_y,
    input  wire raster_pkg::rgb_t tri_color,
    input  wire                   flush,
    input  wire                   full,
    output logic                  raster_ready,
    output logic                  wr_en,
    output raster_pkg::pixel_t    wr_data
);
    import raster_pkg::*;

    logic  load;
    x_t    min_x;
    x_t    max_x;
    y_t    min_y;
    y_t    max_y;
    logic  empty;
    edge_t e1_init;
    edge_t e2_init;
    edge_t e3_init;
    edge_t e1_dx;
    edge_t e2_dx;
    edge_t e3_dx;
    edge_t e1_dy;
    edge_t e2_dy;
    edge_t e3_dy;
    rgb_t  color;

    edge_setup u_setup (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .v1_x      (v1_x),
        .v1_y      (v1_y),
        .v2_x      (v2_x),
        .v2_y      (v2_y),
        .v3_x      (v3_x),
        .v3_y      (v3_y),
        .tri_color (tri_color),
        .min_x     (min_x),
        .max_x     (max_x),
        .min_y     (min_y),
        .max_y     (max_y),
        .empty     (empty),
        .e1_init   (e1_init),
        .e2_init   (e2_init),
        .e3_init   (e3_init),
        .e1_dx     (e1_dx),
        .e2_dx     (e2_dx),
        .e3_dx     (e3_dx),
        .e1_dy     (e1_dy),
        .e2_dy     (e2_dy),
        .e3_dy     (e3_dy),
        .color     (color)
    );

    raster_scan u_scan (
        .clk          (clk),
        .rst_n        (rst_n),
        .tri_valid    (tri_valid),
        .flush        (flush),
        .full         (full),
        .min_x        (min_x),
        .max_x        (max_x),
        .min_y        (min_y),
        .max_y        (max_y),
        .empty        (empty),
        .e1_init      (e1_init),
        .e2_init      (e2_init),
        .e3_init      (e3_init),
        .e1_dx        (e1_dx),
        .e2_dx        (e2_dx),
        .e3_dx        (e3_dx),
        .e1_dy        (e1_dy),
        .e2_dy        (e2_dy),
        .e3_dy        (e3_dy),
        .color        (color),
        .load         (load),
        .raster_ready (raster_ready),
        .wr_en        (wr_en),
        .wr_data      (wr_data)
    );

endmodule

`default_nettype wire

// File: sim/rasterizer_props.sv
`timescale 1ns/1ps
`default_nettype none

module rasterizer_props (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     full,
    input wire                     raster_ready,
    input wire                     wr_en,
    input wire raster_pkg::pixel_t wr_data
);
    import raster_pkg::*;

    // Failed properties so far
    int fail_count = 0;

    // First edge out of reset sees the reset values
    reset_values: assert property (@(posedge clk) $rose(rst_n) |-> !wr_en && raster_ready)
        else
        begin
            fail_count++;
            $error("wr_en high or raster_ready low after reset");
        end

    // A held word must not change under back-pressure
    hold_on_full: assert property (@(posedge clk) disable iff (!rst_n)
        full && wr_en |=> wr_en && $stable(wr_data))
        else
        begin
            fail_count++;
            $error("write port changed while the FIFO was full");
        end

    // Only a pending flush word may overlap with ready
    ready_vs_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(raster_ready && wr_en && (wr_data != flush_word)))
        else
        begin
            fail_count++;
            $error("raster_ready and wr_en high together on a pixel word");
        end

endmodule

`default_nettype wire

// File: sim/tb_rasterizer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rasterizer;
    import raster_pkg::*;

    localparam int n_tris     = 24;
    localparam int wait_limit = 20000;

    logic   clk;
    logic   rst_n;
    logic   tri_valid;
    logic   flush;
    logic   full = 1'b0;
    x_t     v1_x;
    y_t     v1_y;
    x_t     v2_x;
    y_t     v2_y;
    x_t     v3_x;
    y_t     v3_y;
    rgb_t   tri_color;
    logic   raster_ready;
    logic   wr_en;
    pixel_t wr_data;

    logic [31:0] stim_lfsr  = 32'h3b005d38;
    logic [31:0] stall_lfsr = 32'h3b005d38;
    logic        stall_on   = 1'b0;

    pixel_t exp_q [$];
    pixel_t got_q [$];

    x_t   tx [n_tris][3];
    y_t   ty [n_tris][3];
    rgb_t tc [n_tris];

    rasterizer_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .tri_valid    (tri_valid),
        .v1_x         (v1_x),
        .v1_y         (v1_y),
        .v2_x         (v2_x),
        .v2_y         (v2_y),
        .v3_x         (v3_x),
        .v3_y         (v3_y),
        .tri_color    (tri_color),
        .flush        (flush),
        .full         (full),
        .raster_ready (raster_ready),
        .wr_en        (wr_en),
        .wr_data      (wr_data)
    );

    bind raster_scan rasterizer_props u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .full         (full),
        .raster_ready (raster_ready),
        .wr_en        (wr_en),
        .wr_data      (wr_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v         = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_next(stim_lfsr);
        end
        return v;
    endfunction

    // FIFO sink with random back-pressure
    always @(posedge clk)
    begin
        if (rst_n && wr_en && !full)
            got_q.push_back(wr_data);
        if (stall_on)
        begin
            full       <= stall_lfsr[0];
            stall_lfsr <= lfsr_next(stall_lfsr);
        end
        else
            full <= 1'b0;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // Stop at the first failed property
    always @(posedge clk)
    begin
        if (DUT.u_scan.u_props.fail_count != 0)
            fail_run("a bound write port property failed");
    end

    task automatic compare_pixel(input pixel_t want, input pixel_t got, input string what);
        if (got !== want)
            fail_run($sformatf("mismatch at %0t: %s expected %h got %h",
                               $time, what, want, got));
    endtask

    task automatic compare_count(input int want, input int got, input string what);
        if (got != want)
            fail_run($sformatf("mismatch at %0t: %s expected %0d words got %0d",
                               $time, what, want, got));
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!raster_ready)
        begin
            n++;
            if (n > wait_limit)
                fail_run("timeout waiting for raster_ready to return high");
            @(negedge clk);
        end
    endtask

    task automatic check_words(input int start, input string what);
        compare_count(exp_q.size(), got_q.size() - start, what);
        foreach (exp_q[i])
            compare_pixel(exp_q[i], got_q[start + i], what);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic int edge_value(int xi, int yi, int xj, int yj, int x, int y);
        return (xj - xi) * (y - yi) - (yj - yi) * (x - xi);
    endfunction

    task automatic build_expected(input x_t ax, input y_t ay, input x_t bx, input y_t by,
                                  input x_t cx, input y_t cy, input rgb_t c);
        int px [3];
        int py [3];
        int lo_x;
        int hi_x;
        int lo_y;
        int hi_y;
        exp_q.delete();
        px   = '{int'(ax), int'(bx), int'(cx)};
        py   = '{int'(ay), int'(by), int'(cy)};
        lo_x = px[0];
        hi_x = px[0];
        lo_y = py[0];
        hi_y = py[0];
        for (int k = 1; k < 3; k++)
        begin
            lo_x = (px[k] < lo_x) ? px[k] : lo_x;
            hi_x = (px[k] > hi_x) ? px[k] : hi_x;
            lo_y = (py[k] < lo_y) ? py[k] : lo_y;
            hi_y = (py[k] > hi_y) ? py[k] : hi_y;
        end
        // Off-screen minimum leaves an empty range
        hi_x = (hi_x > screen_w - 1) ? screen_w - 1 : hi_x;
        hi_y = (hi_y > screen_h - 1) ? screen_h - 1 : hi_y;
        for (int y = lo_y; y <= hi_y; y++)
            for (int x = lo_x; x <= hi_x; x++)
                if (edge_value(px[0], py[0], px[1], py[1], x, y) >= 0 &&
                    edge_value(px[1], py[1], px[2], py[2], x, y) >= 0 &&
                    edge_value(px[2], py[2], px[0], py[0], x, y) >= 0)
                    exp_q.push_back({y_t'(y), x_t'(x), c});
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic run_triangle(input x_t ax, input y_t ay, input x_t bx, input y_t by,
                                input x_t cx, input y_t cy, input rgb_t c,
                                input logic with_flush, input string what);
        int start;
        build_expected(ax, ay, bx, by, cx, cy, c);
        start = got_q.size();
        @(posedge clk);
        tri_valid <= 1'b1;
        flush     <= with_flush;
        v1_x      <= ax;
        v1_y      <= ay;
        v2_x      <= bx;
        v2_y      <= by;
        v3_x      <= cx;
        v3_y      <= cy;
        tri_color <= c;
        @(posedge clk);
        tri_valid <= 1'b0;
        flush     <= 1'b0;
        // Colour only matters in the accept cycle
        tri_color <= rgb_t'(draw(16));
        wait_ready();
        check_words(start, what);
    endtask

    // Vertices in a 64 by 64 window at the given corner
    task automatic make_set(input int x_base, input int y_base, input int count);
        for (int i = 0; i < count; i++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                tx[i][k] = x_t'(x_base + int'(draw(6)));
                ty[i][k] = y_t'(y_base + int'(draw(6)));
            end
            tc[i] = rgb_t'(draw(16));
        end
    endtask

    task automatic run_set(input int count, input string what);
        for (int i = 0; i < count; i++)
            run_triangle(tx[i][0], ty[i][0], tx[i][1], ty[i][1], tx[i][2], ty[i][2],
                         tc[i], 1'b0, what);
    endtask

    initial
    begin
        int start;
        rst_n     = 1'b0;
        tri_valid = 1'b0;
        flush     = 1'b0;
        v1_x      = '0;
        v1_y      = '0;
        v2_x      = '0;
        v2_y      = '0;
        v3_x      = '0;
        v3_y      = '0;
        tri_color = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_ready();

        // Centre triangles, then the same set under random full
        make_set(288, 208, n_tris);
        run_set(n_tris, "centre triangle");
        stall_on = 1'b1;
        run_set(n_tris, "stalled triangle");

        // Bottom-right corner and beyond
        make_set(608, 448, 8);
        run_set(8, "clipped triangle");
        run_triangle(10'd700, 9'd100, 10'd720, 9'd120, 10'd710, 9'd140, 16'hf800, 1'b0,
                     "off screen right");
        run_triangle(10'd100, 9'd490, 10'd120, 9'd500, 10'd110, 9'd495, 16'h07e0, 1'b0,
                     "off screen below");

        // Degenerate and reversed
        run_triangle(10'd300, 9'd200, 10'd310, 9'd210, 10'd320, 9'd220, 16'h001f, 1'b0,
                     "collinear");
        run_triangle(10'd100, 9'd100, 10'd100, 9'd100, 10'd100, 9'd100, 16'hffe0, 1'b0,
                     "single point");
        run_triangle(tx[0][0], ty[0][0], tx[0][2], ty[0][2], tx[0][1], ty[0][1], tc[0],
                     1'b0, "reversed winding");

        // Flush alone, then flush against a triangle
        start = got_q.size();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        wait_ready();
        compare_count(1, got_q.size() - start, "flush in idle");
        compare_pixel(flush_word, got_q[start], "flush in idle");
        run_triangle(10'd320, 9'd240, 10'd340, 9'd240, 10'd320, 9'd260, 16'h7bef, 1'b1,
                     "flush with triangle");

        if (DUT.u_scan.u_props.fail_count == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
            fail_run("a bound write port property failed");
    end

endmodule

`default_nettype wire

// File: list.f
src/raster_pkg.sv
src/tri_bbox.sv
src/edge_setup.sv
src/raster_scan.sv
src/rasterizer_top.sv
sim/rasterizer_props.sv
sim/tb_rasterizer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_rasterizer
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
